// ==== verilog/bridge_map_pkg.sv ====
// bridge map definitions
// address regions, configuration offsets in both maps and the decoded request
package bridge_map_pkg;

	typedef logic [31:0] bridge_addr_t;
	typedef logic [31:0] bridge_data_t;
	typedef logic [15:0] cfg_ofs_t;
	typedef logic [15:0] port_addr_t;

	typedef enum logic [2:0] {
		REGION_CMD, REGION_CROM_LOAD, REGION_MEMCARD, REGION_BACKUP, REGION_CFG, REGION_OTHER
	} region_e;

	typedef enum logic [4:0] {
		SEL_NONE, SEL_DIPSW, SEL_SYSTEM_TYPE, SEL_MEMCARD_EN, SEL_USE_MOUSE,
		SEL_VIDEO_MODE, SEL_VIDEO_RATIO, SEL_CH_ENABLE, SEL_SND_ENABLE, SEL_USE_PCM,
		SEL_PCHIP_MAIN, SEL_PCHIP_SUB, SEL_CMC_CHIP, SEL_CART_CHIP, SEL_C1_WAIT,
		SEL_V2_OFFSET, SEL_V2ROM_MASK, SEL_SCREEN_X, SEL_SCREEN_Y, SEL_CORE_RESET
	} cfg_sel_e;

	typedef enum logic [2:0] {
		MASK_NONE, MASK_P2, MASK_M, MASK_S, MASK_V1, MASK_CROM
	} mask_sel_e;

	typedef struct packed {
		logic rd;
		logic wr;
		bridge_addr_t addr;
		bridge_data_t wr_data;
	} bridge_req_t;

	typedef struct packed {
		bridge_req_t req;
		region_e region;
		cfg_sel_e cfg_sel;
		mask_sel_e mask_sel;
		logic p2_high;
	} bridge_dec_t;

	// top byte and nibble tags
	localparam bridge_addr_t CFG_BASE = 32'hF000_0000;
	localparam logic [7:0] CMD_BYTE = 8'hF8;
	localparam logic [7:0] LOADER_BYTE = 8'h10;
	localparam logic [3:0] NIB_V1 = 4'h2;
	localparam logic [3:0] NIB_CROM = 4'h4;
	localparam logic [3:0] NIB_MEMCARD = 4'h6;
	localparam logic [3:0] NIB_BACKUP = 4'h7;
	localparam logic [3:0] P2_HIGH_NIB = 4'h8;
	localparam logic [3:0] SROM_NIB = 4'hC;
	localparam logic [4:0] MROM_TAG = 5'h1F;

	// old json map next to the grouped map
	localparam cfg_ofs_t OLD_DIPSW = 16'h0008, NEW_DIPSW = 16'h0104;
	localparam cfg_ofs_t OLD_SYSTEM_TYPE = 16'h000C, NEW_SYSTEM_TYPE = 16'h0108;
	localparam cfg_ofs_t OLD_MEMCARD_EN = 16'h0010, NEW_MEMCARD_EN = 16'h010C;
	localparam cfg_ofs_t OLD_USE_MOUSE = 16'h0014;
	localparam cfg_ofs_t OLD_CH_ENABLE = 16'h001C, NEW_CH_ENABLE = 16'h0300;
	localparam cfg_ofs_t OLD_SND_ENABLE = 16'h0020, NEW_SND_ENABLE = 16'h0304;
	localparam cfg_ofs_t OLD_PCHIP_MAIN = 16'h0024, NEW_PCHIP_MAIN = 16'h0404;
	localparam cfg_ofs_t OLD_USE_PCM = 16'h0028, NEW_USE_PCM = 16'h030C;
	localparam cfg_ofs_t OLD_PCHIP_SUB = 16'h002C, NEW_PCHIP_SUB = 16'h0408;
	localparam cfg_ofs_t OLD_CMC_CHIP = 16'h0030, NEW_CMC_CHIP = 16'h040C;
	localparam cfg_ofs_t OLD_V2_OFFSET = 16'h003C, NEW_V2_OFFSET = 16'h0310;
	localparam cfg_ofs_t OLD_CART_CHIP = 16'h0040, NEW_CART_CHIP = 16'h0410;
	localparam cfg_ofs_t OLD_V2ROM_MASK = 16'h004C, NEW_V2ROM_MASK = 16'h0314;
	localparam cfg_ofs_t OLD_C1_WAIT = 16'h0054, NEW_C1_WAIT = 16'h0400;
	localparam cfg_ofs_t NEW_CORE_RESET = 16'h0100;
	localparam cfg_ofs_t NEW_VIDEO_MODE = 16'h0200;
	localparam cfg_ofs_t NEW_SCREEN_X = 16'h0204;
	localparam cfg_ofs_t NEW_SCREEN_Y = 16'h0208;
	localparam cfg_ofs_t NEW_VIDEO_RATIO = 16'h020C;

endpackage

// ==== verilog/core_cfg_pkg.sv ====
// core configuration definitions
// field types, reset values, restart hold and the snooped ROM mask layout
package core_cfg_pkg;

	typedef logic [7:0] dipsw_t;
	typedef logic [1:0] mode2_t;
	typedef logic [2:0] mode3_t;
	typedef logic [5:0] ch_mask_t;
	typedef logic [3:0] snd_mask_t;
	typedef logic [23:0] rom_span_t;
	typedef logic [18:0] rom19_t;
	typedef logic [25:0] crom_mask_t;
	typedef logic [31:0] screen_pos_t;
	typedef logic [3:0] pchip_t;
	typedef logic [16:0] hold_cnt_t;

	typedef struct packed {
		dipsw_t dipsw;
		mode2_t system_type;
		mode2_t memory_card_enable;
		mode2_t use_mouse;
		logic video_mode;
		mode3_t video_ratio;
		ch_mask_t ch_enable;
		snd_mask_t snd_enable;
		logic use_pcm;
		logic pchip_main;
		mode3_t pchip_sub;
		mode2_t cmc_chip;
		mode2_t cart_chip;
		mode3_t c1_wait;
		rom_span_t v2_offset;
		rom_span_t v2rom_mask;
		screen_pos_t screen_x_pos;
		screen_pos_t screen_y_pos;
	} core_cfg_t;

	typedef struct packed {
		rom_span_t p2rom;
		rom19_t mrom;
		rom19_t srom;
		rom_span_t v1rom;
		crom_mask_t crom;
	} rom_masks_t;

	// dips open, system type 1, every channel and sound enabled
	localparam core_cfg_t CFG_RESET = '{
		dipsw: '1, system_type: 2'd1, ch_enable: '1, snd_enable: '1, default: '0
	};

	localparam hold_cnt_t CORE_RESET_HOLD = 17'd131071;
	// 256 KB, doubled for each of the eight size steps
	localparam crom_mask_t CROM_STEP_BASE = 26'h004_0000;

endpackage

// ==== verilog/bridge_decode.sv ====
// bridge request decode
// registers each strobe with its region, config register and loader mask target
`timescale 1ns/1ps

module bridge_decode (
	input  logic                        clk_74a,
	input  logic                        reset_l_main,
	input  bridge_map_pkg::bridge_req_t req,
	output bridge_map_pkg::bridge_dec_t dec
);
	import bridge_map_pkg::*;

	logic [3:0] nib;
	logic [7:0] top_byte;
	region_e region;
	cfg_sel_e cfg_sel;
	mask_sel_e mask_sel;
	// PROM1 bank as seen by the next P2 write
	logic p2_high;

	assign nib = req.addr[31:28];
	assign top_byte = req.addr[31:24];

	always_comb begin
		if (top_byte == CFG_BASE[31:24])
			region = REGION_CFG;
		else if (top_byte == CMD_BYTE)
			region = REGION_CMD;
		else begin
			case (nib)
				NIB_CROM:    region = REGION_CROM_LOAD;
				NIB_MEMCARD: region = REGION_MEMCARD;
				NIB_BACKUP:  region = REGION_BACKUP;
				// ram windows without a controller
				4'h1, 4'h2, 4'h3, 4'h5: region = REGION_CMD;
				default:     region = REGION_OTHER;
			endcase
		end
	end

	// both maps land on the same select
	always_comb begin
		cfg_sel = SEL_NONE;
		if (region == REGION_CFG) begin
			case (req.addr[15:0])
				OLD_DIPSW, NEW_DIPSW:             cfg_sel = SEL_DIPSW;
				OLD_SYSTEM_TYPE, NEW_SYSTEM_TYPE: cfg_sel = SEL_SYSTEM_TYPE;
				OLD_MEMCARD_EN, NEW_MEMCARD_EN:   cfg_sel = SEL_MEMCARD_EN;
				OLD_USE_MOUSE:                    cfg_sel = SEL_USE_MOUSE;
				OLD_CH_ENABLE, NEW_CH_ENABLE:     cfg_sel = SEL_CH_ENABLE;
				OLD_SND_ENABLE, NEW_SND_ENABLE:   cfg_sel = SEL_SND_ENABLE;
				OLD_PCHIP_MAIN, NEW_PCHIP_MAIN:   cfg_sel = SEL_PCHIP_MAIN;
				OLD_USE_PCM, NEW_USE_PCM:         cfg_sel = SEL_USE_PCM;
				OLD_PCHIP_SUB, NEW_PCHIP_SUB:     cfg_sel = SEL_PCHIP_SUB;
				OLD_CMC_CHIP, NEW_CMC_CHIP:       cfg_sel = SEL_CMC_CHIP;
				OLD_V2_OFFSET, NEW_V2_OFFSET:     cfg_sel = SEL_V2_OFFSET;
				OLD_CART_CHIP, NEW_CART_CHIP:     cfg_sel = SEL_CART_CHIP;
				OLD_V2ROM_MASK, NEW_V2ROM_MASK:   cfg_sel = SEL_V2ROM_MASK;
				OLD_C1_WAIT, NEW_C1_WAIT:         cfg_sel = SEL_C1_WAIT;
				NEW_CORE_RESET:                   cfg_sel = SEL_CORE_RESET;
				NEW_VIDEO_MODE:                   cfg_sel = SEL_VIDEO_MODE;
				NEW_SCREEN_X:                     cfg_sel = SEL_SCREEN_X;
				NEW_SCREEN_Y:                     cfg_sel = SEL_SCREEN_Y;
				NEW_VIDEO_RATIO:                  cfg_sel = SEL_VIDEO_RATIO;
				default:                          cfg_sel = SEL_NONE;
			endcase
		end
	end

	// loader windows for the snooped masks
	always_comb begin
		mask_sel = MASK_NONE;
		if (top_byte == LOADER_BYTE) begin
			if (!req.addr[23])
				mask_sel = MASK_P2;
			else if (req.addr[23:19] == MROM_TAG)
				mask_sel = MASK_M;
			else if (req.addr[23:20] == SROM_NIB)
				mask_sel = MASK_S;
		end else if (nib == NIB_V1)
			mask_sel = MASK_V1;
		else if (nib == NIB_CROM)
			mask_sel = MASK_CROM;
	end

	always_ff @(posedge clk_74a or negedge reset_l_main) begin
		if (!reset_l_main) begin
			dec <= '0;
			p2_high <= 1'b0;
		end else begin
			dec.req <= req;
			dec.region <= region;
			dec.cfg_sel <= cfg_sel;
			dec.mask_sel <= mask_sel;
			dec.p2_high <= p2_high;
			// 0x108 selects the upper bank, any low P2 write drops it
			if (req.wr && top_byte == LOADER_BYTE) begin
				if (req.addr[23:20] == P2_HIGH_NIB)
					p2_high <= 1'b1;
				else if (!req.addr[23])
					p2_high <= 1'b0;
			end
		end
	end

endmodule

// ==== verilog/core_config_regs.sv ====
// core configuration register file
// field writes from the decoded bridge, restart pulse and protection chip code
`timescale 1ns/1ps

module core_config_regs (
	input  logic                        clk_74a,
	input  logic                        reset_l_main,
	input  bridge_map_pkg::bridge_dec_t dec,
	output core_cfg_pkg::core_cfg_t     cfg,
	output core_cfg_pkg::pchip_t        cart_pchip,
	output logic                        core_restart
);
	import bridge_map_pkg::*;
	import core_cfg_pkg::*;

	bridge_data_t wd;
	pchip_t pchip_code;

	assign wd = dec.req.wr_data;

	// main chip wins, sub values 1..5 map to codes 3..7
	always_comb begin
		if (cfg.pchip_main)
			pchip_code = 4'd2;
		else if (cfg.pchip_sub inside {[3'd1:3'd5]})
			pchip_code = {1'b0, cfg.pchip_sub} + 4'd2;
		else
			pchip_code = 4'd0;
	end

	always_ff @(posedge clk_74a or negedge reset_l_main) begin
		if (!reset_l_main) begin
			cfg <= CFG_RESET;
			core_restart <= 1'b0;
			cart_pchip <= '0;
		end else begin
			core_restart <= dec.req.wr && (dec.cfg_sel == SEL_CORE_RESET);
			cart_pchip <= pchip_code;
			if (dec.req.wr) begin
				// wide writes keep only the low bits of each field
				case (dec.cfg_sel)
					SEL_DIPSW:       cfg.dipsw <= dipsw_t'(wd);
					SEL_SYSTEM_TYPE: cfg.system_type <= mode2_t'(wd);
					SEL_MEMCARD_EN:  cfg.memory_card_enable <= mode2_t'(wd);
					SEL_USE_MOUSE:   cfg.use_mouse <= mode2_t'(wd);
					SEL_VIDEO_MODE:  cfg.video_mode <= wd[0];
					SEL_VIDEO_RATIO: cfg.video_ratio <= mode3_t'(wd);
					SEL_CH_ENABLE:   cfg.ch_enable <= ch_mask_t'(wd);
					SEL_SND_ENABLE:  cfg.snd_enable <= snd_mask_t'(wd);
					SEL_USE_PCM:     cfg.use_pcm <= wd[0];
					SEL_PCHIP_MAIN:  cfg.pchip_main <= wd[0];
					SEL_PCHIP_SUB:   cfg.pchip_sub <= mode3_t'(wd);
					SEL_CMC_CHIP:    cfg.cmc_chip <= mode2_t'(wd);
					SEL_CART_CHIP:   cfg.cart_chip <= mode2_t'(wd);
					SEL_C1_WAIT:     cfg.c1_wait <= mode3_t'(wd);
					SEL_V2_OFFSET:   cfg.v2_offset <= rom_span_t'(wd);
					SEL_V2ROM_MASK:  cfg.v2rom_mask <= rom_span_t'(wd);
					SEL_SCREEN_X:    cfg.screen_x_pos <= screen_pos_t'(wd);
					SEL_SCREEN_Y:    cfg.screen_y_pos <= screen_pos_t'(wd);
					default: ;
				endcase
			end
		end
	end

endmodule

// ==== verilog/rom_mask_snoop.sv ====
// ROM size mask snooping
// derives the P2, M, S, V1 and C ROM masks from loader write addresses
`timescale 1ns/1ps

module rom_mask_snoop (
	input  logic                        clk_74a,
	input  logic                        reset_l_main,
	input  bridge_map_pkg::bridge_dec_t dec,
	output core_cfg_pkg::rom_masks_t    masks
);
	import bridge_map_pkg::*;
	import core_cfg_pkg::*;

	rom_span_t sm_p2;
	rom_span_t sm_19;
	rom_span_t sm_v1;
	logic [7:0] crom_hits;
	logic [7:0] crom_flags;

	// each bit is set when it or any bit above it is set
	function automatic rom_span_t smear(input rom_span_t a);
		rom_span_t r;
		r[23] = a[23];
		for (int i = 22; i >= 0; i--)
			r[i] = r[i + 1] | a[i];
		return r;
	endfunction

	assign sm_p2 = smear({1'b0, dec.req.addr[22:0]});
	assign sm_19 = smear({5'd0, dec.req.addr[18:0]});
	assign sm_v1 = smear(dec.req.addr[23:0]);

	// one flag per size step above 256 KB
	always_comb begin
		for (int k = 0; k < 8; k++)
			crom_hits[k] = dec.req.addr[25:0] > (CROM_STEP_BASE << k);
	end

	always_ff @(posedge clk_74a or negedge reset_l_main) begin
		if (!reset_l_main) begin
			masks <= '0;
			crom_flags <= '0;
		end else begin
			masks.crom <= {2'b00, crom_flags, {16{|crom_flags}}};
			if (dec.req.wr) begin
				case (dec.mask_sel)
					MASK_P2:   masks.p2rom <= {dec.p2_high, sm_p2[22:0]};
					MASK_M:    masks.mrom <= sm_19[18:0];
					MASK_S:    masks.srom <= sm_19[18:0];
					MASK_V1:   masks.v1rom <= sm_v1;
					MASK_CROM: crom_flags <= crom_hits;
					default: ;
				endcase
			end
		end
	end

endmodule

// ==== verilog/core_start_ctrl.sv ====
// core start control
// holds start_system low for a fixed count after a restart request
`timescale 1ns/1ps

module core_start_ctrl (
	input  logic clk_74a,
	input  logic reset_l_main,
	input  logic core_restart,
	input  logic dataslot_allcomplete,
	input  logic core_run,
	output logic start_system
);
	import core_cfg_pkg::*;

	hold_cnt_t hold_cnt;

	always_ff @(posedge clk_74a or negedge reset_l_main) begin
		if (!reset_l_main) begin
			hold_cnt <= '0;
			start_system <= 1'b0;
		end else begin
			if (core_restart)
				hold_cnt <= CORE_RESET_HOLD;
			else if (hold_cnt != '0)
				hold_cnt <= hold_cnt - 1'b1;
			// run only once loading is done and the hold has drained
			start_system <= (hold_cnt == '0) && dataslot_allcomplete && core_run;
		end
	end

endmodule

// ==== verilog/bridge_read_mux.sv ====
// bridge read-back
// captures config, memory card or backup RAM data and selects bridge_rd_data
`timescale 1ns/1ps

module bridge_read_mux (
	input  logic                         clk_74a,
	input  logic                         reset_l_main,
	input  bridge_map_pkg::bridge_dec_t  dec,
	input  core_cfg_pkg::core_cfg_t      cfg,
	input  bridge_map_pkg::bridge_data_t memcard_din,
	input  bridge_map_pkg::bridge_data_t backup_din,
	input  bridge_map_pkg::bridge_data_t cmd_rd_data,
	output bridge_map_pkg::bridge_data_t bridge_rd_data
);
	import bridge_map_pkg::*;

	bridge_data_t cfg_word;
	bridge_data_t rd_capture;
	region_e rd_region;

	always_comb begin
		case (dec.cfg_sel)
			SEL_DIPSW:       cfg_word = bridge_data_t'(cfg.dipsw);
			SEL_SYSTEM_TYPE: cfg_word = bridge_data_t'(cfg.system_type);
			SEL_MEMCARD_EN:  cfg_word = bridge_data_t'(cfg.memory_card_enable);
			SEL_USE_MOUSE:   cfg_word = bridge_data_t'(cfg.use_mouse);
			SEL_VIDEO_MODE:  cfg_word = bridge_data_t'(cfg.video_mode);
			SEL_VIDEO_RATIO: cfg_word = bridge_data_t'(cfg.video_ratio);
			SEL_CH_ENABLE:   cfg_word = bridge_data_t'(cfg.ch_enable);
			SEL_SND_ENABLE:  cfg_word = bridge_data_t'(cfg.snd_enable);
			SEL_USE_PCM:     cfg_word = bridge_data_t'(cfg.use_pcm);
			SEL_PCHIP_MAIN:  cfg_word = bridge_data_t'(cfg.pchip_main);
			SEL_PCHIP_SUB:   cfg_word = bridge_data_t'(cfg.pchip_sub);
			SEL_CMC_CHIP:    cfg_word = bridge_data_t'(cfg.cmc_chip);
			SEL_CART_CHIP:   cfg_word = bridge_data_t'(cfg.cart_chip);
			SEL_C1_WAIT:     cfg_word = bridge_data_t'(cfg.c1_wait);
			SEL_V2_OFFSET:   cfg_word = bridge_data_t'(cfg.v2_offset);
			SEL_V2ROM_MASK:  cfg_word = bridge_data_t'(cfg.v2rom_mask);
			SEL_SCREEN_X:    cfg_word = cfg.screen_x_pos;
			SEL_SCREEN_Y:    cfg_word = cfg.screen_y_pos;
			// unknown offsets and the restart register read as zero
			default:         cfg_word = '0;
		endcase
	end

	always_ff @(posedge clk_74a or negedge reset_l_main) begin
		if (!reset_l_main)
			rd_region <= REGION_OTHER;
		else if (dec.req.rd)
			rd_region <= dec.region;
	end

	always_ff @(posedge clk_74a) begin
		if (dec.req.rd) begin
			case (dec.region)
				REGION_CFG:     rd_capture <= cfg_word;
				REGION_MEMCARD: rd_capture <= memcard_din;
				REGION_BACKUP:  rd_capture <= backup_din;
				default:        rd_capture <= '0;
			endcase
		end
	end

	// held until the next read, command data passes straight through
	always_comb begin
		case (rd_region)
			REGION_CFG, REGION_MEMCARD, REGION_BACKUP: bridge_rd_data = rd_capture;
			default: bridge_rd_data = cmd_rd_data;
		endcase
	end

endmodule

// ==== verilog/apf_io.sv ====
// bridge I/O handoff top level
// decode stage feeding config, mask snoop, core start and read-back stages
`timescale 1ns/1ps

module apf_io (
	input  logic                         clk_74a,
	input  logic                         reset_l_main,
	input  logic                         bridge_rd,
	input  logic                         bridge_wr,
	input  bridge_map_pkg::bridge_addr_t bridge_addr,
	input  bridge_map_pkg::bridge_data_t bridge_wr_data,
	output bridge_map_pkg::bridge_data_t bridge_rd_data,
	input  bridge_map_pkg::bridge_data_t cmd_rd_data,
	input  logic                         dataslot_allcomplete,
	input  logic                         core_run,
	output logic                         start_system,
	output core_cfg_pkg::core_cfg_t      cfg,
	output core_cfg_pkg::pchip_t         cart_pchip,
	output core_cfg_pkg::rom_masks_t     masks,
	output bridge_map_pkg::port_addr_t   memcard_addr,
	output logic                         memcard_wr,
	output bridge_map_pkg::bridge_data_t memcard_dout,
	input  bridge_map_pkg::bridge_data_t memcard_din,
	output bridge_map_pkg::port_addr_t   backup_addr,
	output logic                         backup_wr,
	output bridge_map_pkg::bridge_data_t backup_dout,
	input  bridge_map_pkg::bridge_data_t backup_din
);
	import bridge_map_pkg::*;

	bridge_req_t req;
	bridge_dec_t dec;
	logic core_restart;

	assign req = '{rd: bridge_rd, wr: bridge_wr, addr: bridge_addr, wr_data: bridge_wr_data};

	// write ports taken from the decode register
	assign memcard_wr = dec.req.wr && (dec.region == REGION_MEMCARD);
	assign memcard_addr = dec.req.addr[15:0];
	assign memcard_dout = dec.req.wr_data;
	assign backup_wr = dec.req.wr && (dec.region == REGION_BACKUP);
	assign backup_addr = dec.req.addr[15:0];
	assign backup_dout = dec.req.wr_data;

	bridge_decode u_decode (
		.clk_74a(clk_74a), .reset_l_main(reset_l_main),
		.req(req), .dec(dec)
	);

	core_config_regs u_cfg_regs (
		.clk_74a(clk_74a), .reset_l_main(reset_l_main), .dec(dec),
		.cfg(cfg), .cart_pchip(cart_pchip), .core_restart(core_restart)
	);

	rom_mask_snoop u_mask_snoop (
		.clk_74a(clk_74a), .reset_l_main(reset_l_main),
		.dec(dec), .masks(masks)
	);

	core_start_ctrl u_start (
		.clk_74a(clk_74a), .reset_l_main(reset_l_main),
		.core_restart(core_restart),
		.dataslot_allcomplete(dataslot_allcomplete),
		.core_run(core_run),
		.start_system(start_system)
	);

	bridge_read_mux u_read_mux (
		.clk_74a(clk_74a), .reset_l_main(reset_l_main),
		.dec(dec), .cfg(cfg),
		.memcard_din(memcard_din), .backup_din(backup_din),
		.cmd_rd_data(cmd_rd_data), .bridge_rd_data(bridge_rd_data)
	);

endmodule

// ==== dv/apf_io_checker.sv ====
// checker for the bridge I/O handoff
// samples DUT outputs at each step's latency and compares with the expected value
`timescale 1ns/1ps

module apf_io_checker (
	input  logic                         clk_74a,
	input  logic                         go,
	input  logic [127:0]                 sig_name,
	input  logic [3:0]                   lat,
	input  logic [31:0]                  exp_val,
	input  logic [15:0]                  exp_addr,
	input  bridge_map_pkg::bridge_data_t bridge_rd_data,
	input  logic                         start_system,
	input  core_cfg_pkg::core_cfg_t      cfg,
	input  core_cfg_pkg::pchip_t         cart_pchip,
	input  core_cfg_pkg::rom_masks_t     masks,
	input  logic                         memcard_wr,
	input  bridge_map_pkg::port_addr_t   memcard_addr,
	input  bridge_map_pkg::bridge_data_t memcard_dout,
	input  logic                         backup_wr,
	input  bridge_map_pkg::port_addr_t   backup_addr,
	input  bridge_map_pkg::bridge_data_t backup_dout,
	output int                           n_tests,
	output int                           n_errors
);
	import core_cfg_pkg::*;

	// latest edge after the restart write at which start_system may rise
	localparam int RISE_LIMIT = CORE_RESET_HOLD + 4;

	initial begin
		n_tests = 0;
		n_errors = 0;
	end

	task automatic compare(input logic [127:0] name, input logic [31:0] got,
			input logic [31:0] want);
		if (got !== want) begin
			$display("** Error at %0t ns: %0s is 0x%08h, expected 0x%08h",
				$time, name, got, want);
			n_errors++;
		end
	endtask

	task automatic fail_step(input string what);
		$display("at %0t ns: %s", $time, what);
		n_errors++;
	endtask

	// t counts falling edges since the strobe edge
	task automatic check_start_up();
		int t;
		t = 1;
		@(negedge clk_74a);
		while (!start_system && t < 4) begin
			@(negedge clk_74a);
			t++;
		end
		if (!start_system)
			fail_step("start_system did not rise after loading completed");
	endtask

	task automatic check_restart();
		int t;
		int low_cnt;
		t = 1;
		low_cnt = 0;
		@(negedge clk_74a);
		while (start_system && t < 4) begin
			@(negedge clk_74a);
			t++;
		end
		if (start_system) begin
			fail_step("start_system did not drop within 4 cycles of the restart write");
		end else begin
			while (!start_system && t < RISE_LIMIT) begin
				@(negedge clk_74a);
				t++;
				low_cnt++;
			end
			if (!start_system)
				fail_step("start_system did not rise within the restart hold window");
			else if (low_cnt < CORE_RESET_HOLD)
				fail_step("start_system rose before the restart hold count ran out");
		end
	endtask

	task automatic run_check();
		int errs_before;
		errs_before = n_errors;
		if (sig_name == "start_up") begin
			check_start_up();
		end else if (sig_name == "start_restart") begin
			check_restart();
		end else begin
			repeat (lat - 1) @(posedge clk_74a);
			@(negedge clk_74a);
			case (sig_name)
				"start_system":   compare(sig_name, start_system, exp_val);
				"dipsw":          compare(sig_name, cfg.dipsw, exp_val);
				"system_type":    compare(sig_name, cfg.system_type, exp_val);
				"memcard_enable": compare(sig_name, cfg.memory_card_enable, exp_val);
				"use_mouse":      compare(sig_name, cfg.use_mouse, exp_val);
				"video_mode":     compare(sig_name, cfg.video_mode, exp_val);
				"video_ratio":    compare(sig_name, cfg.video_ratio, exp_val);
				"ch_enable":      compare(sig_name, cfg.ch_enable, exp_val);
				"snd_enable":     compare(sig_name, cfg.snd_enable, exp_val);
				"use_pcm":        compare(sig_name, cfg.use_pcm, exp_val);
				"pchip_sub":      compare(sig_name, cfg.pchip_sub, exp_val);
				"cmc_chip":       compare(sig_name, cfg.cmc_chip, exp_val);
				"cart_chip":      compare(sig_name, cfg.cart_chip, exp_val);
				"c1_wait":        compare(sig_name, cfg.c1_wait, exp_val);
				"v2_offset":      compare(sig_name, cfg.v2_offset, exp_val);
				"v2rom_mask":     compare(sig_name, cfg.v2rom_mask, exp_val);
				"screen_x_pos":   compare(sig_name, cfg.screen_x_pos, exp_val);
				"screen_y_pos":   compare(sig_name, cfg.screen_y_pos, exp_val);
				"cart_pchip":     compare(sig_name, cart_pchip, exp_val);
				"p2rom":          compare(sig_name, masks.p2rom, exp_val);
				"mrom":           compare(sig_name, masks.mrom, exp_val);
				"srom":           compare(sig_name, masks.srom, exp_val);
				"v1rom":          compare(sig_name, masks.v1rom, exp_val);
				"crom":           compare(sig_name, masks.crom, exp_val);
				"bridge_rd_data": compare(sig_name, bridge_rd_data, exp_val);
				"memcard_port": begin
					compare("memcard_wr", memcard_wr, 32'h1);
					compare("backup_wr", backup_wr, 32'h0);
					compare("memcard_addr", memcard_addr, exp_addr);
					compare("memcard_dout", memcard_dout, exp_val);
				end
				"backup_port": begin
					compare("backup_wr", backup_wr, 32'h1);
					compare("memcard_wr", memcard_wr, 32'h0);
					compare("backup_addr", backup_addr, exp_addr);
					compare("backup_dout", backup_dout, exp_val);
				end
				default: fail_step("the step names a signal that the checker does not know");
			endcase
		end
		$display("test %0d %0s: %s", n_tests + 1, sig_name,
			(n_errors == errs_before) ? "pass" : "fail");
		n_tests++;
	endtask

	always @(posedge clk_74a) begin
		if (go)
			run_check();
	end

endmodule

// ==== dv/tb_apf_io.sv ====
// testbench for the bridge I/O handoff
// plays a table of bridge steps into the DUT while the checker compares outputs
`timescale 1ns/1ps

module tb_apf_io;
	import bridge_map_pkg::*;
	import core_cfg_pkg::*;

	localparam int STEP_TIMEOUT = 200000;
	localparam logic [1:0] OP_IDLE = 2'd0;
	localparam logic [1:0] OP_WR = 2'd1;
	localparam logic [1:0] OP_RD = 2'd2;
	localparam logic [1:0] OP_RUN = 2'd3;
	// where the expected value of a step comes from
	localparam logic [1:0] SRC_TABLE = 2'd0;
	localparam logic [1:0] SRC_MEMCARD = 2'd1;
	localparam logic [1:0] SRC_BACKUP = 2'd2;
	localparam logic [1:0] SRC_CMD = 2'd3;

	typedef struct packed {
		logic [1:0] op;
		bridge_addr_t addr;
		bridge_data_t data;
		logic [127:0] sig_name;
		logic [3:0] lat;
		logic [1:0] src;
		logic [31:0] exp_val;
	} step_t;

	logic clk_74a = 1'b0;
	logic reset_l_main;
	logic bridge_rd;
	logic bridge_wr;
	bridge_addr_t bridge_addr;
	bridge_data_t bridge_wr_data;
	bridge_data_t bridge_rd_data;
	bridge_data_t cmd_rd_data;
	logic dataslot_allcomplete;
	logic core_run;
	logic start_system;
	core_cfg_t cfg;
	pchip_t cart_pchip;
	rom_masks_t masks;
	port_addr_t memcard_addr;
	logic memcard_wr;
	bridge_data_t memcard_dout;
	bridge_data_t memcard_din;
	port_addr_t backup_addr;
	logic backup_wr;
	bridge_data_t backup_dout;
	bridge_data_t backup_din;

	// checker side of each step
	logic chk_go;
	logic [127:0] chk_name;
	logic [3:0] chk_lat;
	logic [31:0] chk_exp;
	logic [15:0] chk_addr;
	int n_tests;
	int n_errors;

	step_t steps [0:79];
	step_t cur;
	int n_steps;
	int i;
	int wait_cnt;
	logic timed_out;
	int unsigned seed;
	bridge_data_t mc_val;
	bridge_data_t bk_val;
	bridge_data_t cmd_val;
	logic [31:0] want;

	always #2 clk_74a = ~clk_74a;

	apf_io i_dut (
		.clk_74a(clk_74a), .reset_l_main(reset_l_main),
		.bridge_rd(bridge_rd), .bridge_wr(bridge_wr),
		.bridge_addr(bridge_addr), .bridge_wr_data(bridge_wr_data),
		.bridge_rd_data(bridge_rd_data), .cmd_rd_data(cmd_rd_data),
		.dataslot_allcomplete(dataslot_allcomplete), .core_run(core_run),
		.start_system(start_system), .cfg(cfg), .cart_pchip(cart_pchip), .masks(masks),
		.memcard_addr(memcard_addr), .memcard_wr(memcard_wr),
		.memcard_dout(memcard_dout), .memcard_din(memcard_din),
		.backup_addr(backup_addr), .backup_wr(backup_wr),
		.backup_dout(backup_dout), .backup_din(backup_din)
	);

	apf_io_checker i_chk (
		.clk_74a(clk_74a), .go(chk_go), .sig_name(chk_name), .lat(chk_lat),
		.exp_val(chk_exp), .exp_addr(chk_addr),
		.bridge_rd_data(bridge_rd_data), .start_system(start_system),
		.cfg(cfg), .cart_pchip(cart_pchip), .masks(masks),
		.memcard_wr(memcard_wr), .memcard_addr(memcard_addr), .memcard_dout(memcard_dout),
		.backup_wr(backup_wr), .backup_addr(backup_addr), .backup_dout(backup_dout),
		.n_tests(n_tests), .n_errors(n_errors)
	);

	task automatic add_step(input logic [1:0] op, input bridge_addr_t addr,
			input bridge_data_t data, input logic [127:0] name, input logic [3:0] lat,
			input logic [1:0] src, input logic [31:0] exp_val);
		steps[n_steps] = '{op, addr, data, name, lat, src, exp_val};
		n_steps++;
	endtask

	task automatic build_table();
		// reset state and core start
		add_step(OP_IDLE, 32'h0, 32'h0, "start_system", 4'd1, SRC_TABLE, 32'h0);
		add_step(OP_IDLE, 32'h0, 32'h0, "dipsw", 4'd1, SRC_TABLE, 32'hFF);
		add_step(OP_IDLE, 32'h0, 32'h0, "system_type", 4'd1, SRC_TABLE, 32'h1);
		add_step(OP_IDLE, 32'h0, 32'h0, "ch_enable", 4'd1, SRC_TABLE, 32'h3F);
		add_step(OP_IDLE, 32'h0, 32'h0, "snd_enable", 4'd1, SRC_TABLE, 32'hF);
		add_step(OP_IDLE, 32'h0, 32'h0, "cart_pchip", 4'd1, SRC_TABLE, 32'h0);
		add_step(OP_IDLE, 32'h0, 32'h0, "v2_offset", 4'd1, SRC_TABLE, 32'h0);
		add_step(OP_IDLE, 32'h0, 32'h0, "memcard_enable", 4'd1, SRC_TABLE, 32'h0);
		add_step(OP_IDLE, 32'h0, 32'h0, "use_mouse", 4'd1, SRC_TABLE, 32'h0);
		add_step(OP_IDLE, 32'h0, 32'h0, "video_mode", 4'd1, SRC_TABLE, 32'h0);
		add_step(OP_IDLE, 32'h0, 32'h0, "video_ratio", 4'd1, SRC_TABLE, 32'h0);
		add_step(OP_IDLE, 32'h0, 32'h0, "use_pcm", 4'd1, SRC_TABLE, 32'h0);
		add_step(OP_IDLE, 32'h0, 32'h0, "pchip_sub", 4'd1, SRC_TABLE, 32'h0);
		add_step(OP_IDLE, 32'h0, 32'h0, "cmc_chip", 4'd1, SRC_TABLE, 32'h0);
		add_step(OP_IDLE, 32'h0, 32'h0, "cart_chip", 4'd1, SRC_TABLE, 32'h0);
		add_step(OP_IDLE, 32'h0, 32'h0, "c1_wait", 4'd1, SRC_TABLE, 32'h0);
		add_step(OP_IDLE, 32'h0, 32'h0, "v2rom_mask", 4'd1, SRC_TABLE, 32'h0);
		add_step(OP_IDLE, 32'h0, 32'h0, "screen_x_pos", 4'd1, SRC_TABLE, 32'h0);
		add_step(OP_IDLE, 32'h0, 32'h0, "screen_y_pos", 4'd1, SRC_TABLE, 32'h0);
		add_step(OP_RD, 32'hF000_0024, 32'h0, "bridge_rd_data", 4'd2, SRC_TABLE, 32'h0);
		add_step(OP_RUN, 32'h0, 32'h0, "start_up", 4'd0, SRC_TABLE, 32'h1);
		// config writes through both maps truncated to the field width
		add_step(OP_WR, 32'hF000_0008, 32'h1234_56A5, "dipsw", 4'd2, SRC_TABLE, 32'hA5);
		add_step(OP_WR, 32'hF000_0108, 32'hFFFF_FFFE, "system_type", 4'd2, SRC_TABLE, 32'h2);
		add_step(OP_WR, 32'hF000_0300, 32'h0000_00D5, "ch_enable", 4'd2, SRC_TABLE, 32'h15);
		add_step(OP_WR, 32'hF000_0310, 32'hAB12_3456, "v2_offset", 4'd2, SRC_TABLE,
			32'h12_3456);
		add_step(OP_WR, 32'hF000_0204, 32'hDEAD_BEEF, "screen_x_pos", 4'd2, SRC_TABLE,
			32'hDEAD_BEEF);
		add_step(OP_WR, 32'hF000_0020, 32'h0000_0035, "snd_enable", 4'd2, SRC_TABLE, 32'h5);
		add_step(OP_WR, 32'hF000_0010, 32'h6, "memcard_enable", 4'd2, SRC_TABLE, 32'h2);
		add_step(OP_WR, 32'hF000_0014, 32'h5, "use_mouse", 4'd2, SRC_TABLE, 32'h1);
		add_step(OP_WR, 32'hF000_0200, 32'h3, "video_mode", 4'd2, SRC_TABLE, 32'h1);
		add_step(OP_WR, 32'hF000_020C, 32'hE, "video_ratio", 4'd2, SRC_TABLE, 32'h6);
		add_step(OP_WR, 32'hF000_030C, 32'h1, "use_pcm", 4'd2, SRC_TABLE, 32'h1);
		add_step(OP_WR, 32'hF000_0030, 32'h7, "cmc_chip", 4'd2, SRC_TABLE, 32'h3);
		add_step(OP_WR, 32'hF000_0410, 32'h2, "cart_chip", 4'd2, SRC_TABLE, 32'h2);
		add_step(OP_WR, 32'hF000_0054, 32'hD, "c1_wait", 4'd2, SRC_TABLE, 32'h5);
		add_step(OP_WR, 32'hF000_0314, 32'h0FFF_FFFF, "v2rom_mask", 4'd2, SRC_TABLE,
			32'hFF_FFFF);
		add_step(OP_WR, 32'hF000_0208, 32'h8000_0001, "screen_y_pos", 4'd2, SRC_TABLE,
			32'h8000_0001);
		add_step(OP_RD, 32'hF000_0008, 32'h0, "bridge_rd_data", 4'd2, SRC_TABLE, 32'hA5);
		add_step(OP_RD, 32'hF000_001C, 32'h0, "bridge_rd_data", 4'd2, SRC_TABLE, 32'h15);
		add_step(OP_RD, 32'hF000_003C, 32'h0, "bridge_rd_data", 4'd2, SRC_TABLE, 32'h12_3456);
		add_step(OP_RD, 32'hF000_0050, 32'h0, "bridge_rd_data", 4'd2, SRC_TABLE, 32'h0);
		// protection chip code
		add_step(OP_WR, 32'hF000_002C, 32'h3, "cart_pchip", 4'd3, SRC_TABLE, 32'h5);
		add_step(OP_WR, 32'hF000_0024, 32'h1, "cart_pchip", 4'd3, SRC_TABLE, 32'h2);
		add_step(OP_WR, 32'hF000_0404, 32'h0, "cart_pchip", 4'd3, SRC_TABLE, 32'h5);
		add_step(OP_WR, 32'hF000_0408, 32'h6, "cart_pchip", 4'd3, SRC_TABLE, 32'h0);
		add_step(OP_WR, 32'hF000_0408, 32'h9, "cart_pchip", 4'd3, SRC_TABLE, 32'h3);
		// loader snooping with the P2 top bit following the high bank flag
		add_step(OP_WR, 32'h1012_3456, 32'h0, "p2rom", 4'd2, SRC_TABLE, 32'h1F_FFFF);
		add_step(OP_WR, 32'h1080_0000, 32'h0, "p2rom", 4'd2, SRC_TABLE, 32'h1F_FFFF);
		add_step(OP_WR, 32'h1000_0102, 32'h0, "p2rom", 4'd2, SRC_TABLE, 32'h80_01FF);
		add_step(OP_WR, 32'h1000_0010, 32'h0, "p2rom", 4'd2, SRC_TABLE, 32'h1F);
		add_step(OP_WR, 32'h10F8_4321, 32'h0, "mrom", 4'd2, SRC_TABLE, 32'h7FFF);
		add_step(OP_WR, 32'h10C2_0001, 32'h0, "srom", 4'd2, SRC_TABLE, 32'h3_FFFF);
		add_step(OP_WR, 32'h2034_5678, 32'h0, "v1rom", 4'd2, SRC_TABLE, 32'h3F_FFFF);
		add_step(OP_WR, 32'h4050_0000, 32'h0, "crom", 4'd3, SRC_TABLE, 32'h1F_FFFF);
		add_step(OP_WR, 32'h4001_0000, 32'h0, "crom", 4'd3, SRC_TABLE, 32'h0);
		// memory card and backup RAM ports and command data read-back
		add_step(OP_WR, 32'h6001_2344, 32'hCAFE_F00D, "memcard_port", 4'd1, SRC_TABLE,
			32'hCAFE_F00D);
		add_step(OP_WR, 32'h7ABC_0010, 32'h1357_9BDF, "backup_port", 4'd1, SRC_TABLE,
			32'h1357_9BDF);
		add_step(OP_RD, 32'h6000_0040, 32'h0, "bridge_rd_data", 4'd2, SRC_MEMCARD, 32'h0);
		add_step(OP_RD, 32'h7000_0020, 32'h0, "bridge_rd_data", 4'd2, SRC_BACKUP, 32'h0);
		add_step(OP_RD, 32'h1000_0000, 32'h0, "bridge_rd_data", 4'd2, SRC_CMD, 32'h0);
		add_step(OP_RD, 32'hF800_0000, 32'h0, "bridge_rd_data", 4'd2, SRC_CMD, 32'h0);
		add_step(OP_WR, 32'hF000_0100, 32'h1, "start_restart", 4'd0, SRC_TABLE, 32'h0);
	endtask

	initial begin
		reset_l_main = 1'b0;
		bridge_rd = 1'b0;
		bridge_wr = 1'b0;
		bridge_addr = '0;
		bridge_wr_data = '0;
		cmd_rd_data = '0;
		memcard_din = '0;
		backup_din = '0;
		dataslot_allcomplete = 1'b0;
		core_run = 1'b0;
		chk_go = 1'b0;
		chk_name = '0;
		chk_lat = '0;
		chk_exp = '0;
		chk_addr = '0;
		timed_out = 1'b0;
		n_steps = 0;
		seed = 32'hec23_5a05;
		mc_val = $urandom(seed);
		build_table();

		repeat (2) @(posedge clk_74a);
		reset_l_main <= 1'b1;

		i = 0;
		while (i < n_steps && !timed_out) begin
			cur = steps[i];
			@(posedge clk_74a);
			mc_val = $urandom;
			bk_val = $urandom;
			cmd_val = $urandom;
			case (cur.src)
				SRC_MEMCARD: want = mc_val;
				SRC_BACKUP:  want = bk_val;
				SRC_CMD:     want = cmd_val;
				default:     want = cur.exp_val;
			endcase
			memcard_din <= mc_val;
			backup_din <= bk_val;
			cmd_rd_data <= cmd_val;
			bridge_wr <= (cur.op == OP_WR);
			bridge_rd <= (cur.op == OP_RD);
			bridge_addr <= cur.addr;
			bridge_wr_data <= cur.data;
			if (cur.op == OP_RUN) begin
				dataslot_allcomplete <= 1'b1;
				core_run <= 1'b1;
			end
			chk_go <= 1'b1;
			chk_name <= cur.sig_name;
			chk_lat <= cur.lat;
			chk_exp <= want;
			chk_addr <= cur.addr[15:0];
			@(posedge clk_74a);
			bridge_wr <= 1'b0;
			bridge_rd <= 1'b0;
			chk_go <= 1'b0;
			// the checker counts the step once it has compared
			wait_cnt = 0;
			while (n_tests != i + 1 && wait_cnt < STEP_TIMEOUT) begin
				@(posedge clk_74a);
				wait_cnt++;
			end
			if (n_tests != i + 1) begin
				timed_out = 1'b1;
				$display("step %0d timed out waiting for the checker", i + 1);
			end
			i++;
		end

		$display("%0d tests run, %0d errors", n_tests, n_errors);
		if (timed_out || n_errors != 0) begin
			$display("Simulation failed");
		end else begin
			$display("Simulation completed successfully");
		end
		$finish;
	end

endmodule

// ==== sim.f ====
verilog/bridge_map_pkg.sv
verilog/core_cfg_pkg.sv
verilog/bridge_decode.sv
verilog/core_config_regs.sv
verilog/rom_mask_snoop.sv
verilog/core_start_ctrl.sv
verilog/bridge_read_mux.sv
verilog/apf_io.sv
dv/apf_io_checker.sv
dv/tb_apf_io.sv
